// ==== hw/main_bus_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types and constants for the main CPU bus glue.
// Import with main_bus_pkg::* in the module header of each block.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package main_bus_pkg;

    localparam int ADDR_W     = 23;  // A23..A1
    localparam int WORD_W     = 16;
    localparam int BYTE_W     = 8;
    localparam int EXT_ADDR_W = 21;  // A21..A1 to SDRAM

    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [BYTE_W-1:0]     byte_t;
    typedef logic [EXT_ADDR_W-1:0] ext_addr_t;

    // memory map, compared against the top address bits
    localparam logic [3:0] REGION_BOOT     = 4'h0;   // A23..A20, read only
    localparam logic [3:0] REGION_XROM_A   = 4'h1;
    localparam logic [3:0] REGION_XROM_B   = 4'h2;
    localparam logic [3:0] REGION_CPAL_RAM = 4'h3;   // A19 picks palette or work RAM
    localparam logic [2:0] REGION_GFX      = 3'b011; // A23..A21
    localparam logic [2:0] REGION_MISC     = 3'b010;

    localparam logic [2:0] IPL_VBLANK = ~3'd5;  // level 5, active low

    typedef struct packed {
        addr_t      addr;
        logic       as_n;
        logic [1:0] ds_n;   // upper, lower
        logic       rnw;
        word_t      wdata;
    } cpu_bus_t;

    typedef struct packed {
        logic rom, ram, cpal, vmem, lmem, pmem, objreg, objram;
        logic objcha, pair, sdon, ccu, sys1, sys2, cab1, cab2;
    } bus_sel_t;

    typedef struct packed {
        logic [1:0]  cpal_we, vmem_we, omem_we, lmem_we;
        logic [2:0]  pmem_we;    // bit n writes pmem n
        logic        pair_we;
        logic [10:0] cpal_addr;
        logic [11:0] vmem_addr;
        logic [14:0] pmem_addr;
    } mem_wr_t;

    typedef struct packed {
        word_t rom, ram, cpal, omem, lmem, vmem;
        byte_t pmem0, pmem1, pmem2, pair, vtimer;
    } mem_rd_t;

    typedef struct packed {
        logic [6:0] joy1, joy2, joy3, joy4;
        logic [3:0] start, coin, service;
        logic [3:0] dipsw;
        logic       dip_test, eep_do, eep_rdy, odma;
    } cab_in_t;

    typedef struct packed {
        logic       pri, gvflip, ghflip, lrsw;
        logic [3:0] psac_bank;
    } video_cfg_t;

    typedef enum logic [2:0] {
        idle, wait_mem, wait_pxl, ack, hold
    } dtack_state_e;

endpackage

// ==== hw/main_addr_decode.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory map decoder for the main CPU. Purely combinational: turns the
// address and strobes into region selects and the external ROM/RAM address.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module main_addr_decode import main_bus_pkg::*; (
    input  cpu_bus_t  bus,
    output bus_sel_t  sel,
    output ext_addr_t main_addr
);

    addr_t a;       // a[n] is A(n+1)
    logic  cyc;
    logic  boot;

    assign a   = bus.addr;
    assign cyc = !bus.as_n && !(&bus.ds_n);   // address strobe plus a data strobe

    always_comb begin
        sel  = '0;
        boot = 1'b0;
        if (cyc) begin
            boot     = a[22:19] == REGION_BOOT && bus.rnw;
            sel.rom  = boot || a[22:19] == REGION_XROM_A || a[22:19] == REGION_XROM_B;
            sel.cpal = a[22:19] == REGION_CPAL_RAM && !a[18];
            sel.ram  = a[22:19] == REGION_CPAL_RAM &&  a[18];

            // graphics block, split by A20..A18
            if (a[22:20] == REGION_GFX) begin
                case (a[19:17])
                    3'd0:    sel.objram = 1'b1;
                    3'd1:    sel.objreg = 1'b1;
                    3'd3:    sel.pmem   = 1'b1;   // PSAC video RAM
                    3'd4:    sel.lmem   = 1'b1;   // PSAC line RAM
                    3'd5:    sel.vmem   = 1'b1;   // fix layer
                    default: ;
                endcase
            end

            if (a[22:20] == REGION_MISC) begin
                case (a[19:17])
                    3'd7: sel.objcha = 1'b1;
                    3'd6: sel.pair   = 1'b1;
                    3'd5: sel.sdon   = 1'b1;
                    3'd3: sel.ccu    = 1'b1;
                    3'd2: begin
                        // I/O block uses A3..A2
                        case (a[2:1])
                            2'd0: sel.cab1 = 1'b1;
                            2'd1: sel.cab2 = 1'b1;
                            2'd2: sel.sys1 = 1'b1;
                            2'd3: sel.sys2 = 1'b1;
                        endcase
                    end
                    default: ;
                endcase
            end
        end
    end

    // ROM banks are laid out differently in SDRAM
    always_comb begin
        main_addr = a[20:0];
        if (sel.rom) begin
            case (a[20:19])
                2'd1:    main_addr[20:19] = 2'b10;
                2'd2:    main_addr[20:19] = 2'b01;
                default: main_addr[20:19] = 2'b00;  // boot area
            endcase
        end
    end

endmodule

// ==== hw/main_sys_latch.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Byte-writable 16-bit system register, loaded by CPU write cycles.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module main_sys_latch import main_bus_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     sel,
    input  cpu_bus_t bus,
    output word_t    q
);

    logic wr;

    assign wr = sel && !bus.rnw;

    always_ff @(posedge clk) begin
        if (reset) begin
            q <= '0;
        end else if (wr) begin
            if (!bus.ds_n[1]) q[15:8] <= bus.wdata[15:8];  // UDS
            if (!bus.ds_n[0]) q[7:0]  <= bus.wdata[7:0];   // LDS
        end
    end

endmodule

// ==== hw/main_vblank_irq.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Vertical blank interrupt. Latches the start of blanking and presents
// it to the CPU as an encoded level 5 request until software masks it.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module main_vblank_irq import main_bus_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       lvbl,
    input  logic       enable,
    output logic [2:0] ipl_n
);

    logic lvbl_l;
    logic flag;

    always_ff @(posedge clk) begin
        if (reset) begin
            lvbl_l <= 1'b0;
            flag   <= 1'b0;
        end else begin
            lvbl_l <= lvbl;
            if (!enable)
                flag <= 1'b0;        // masking also acknowledges
            else if (lvbl_l && !lvbl)
                flag <= 1'b1;        // blanking starts
        end
    end

    assign ipl_n = flag ? IPL_VBLANK : 3'b111;

endmodule

// ==== hw/main_dtack.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DTACK generator. ROM and RAM cycles wait for the SDRAM ok signals,
// fix RAM cycles wait for the pixel clock enable, the rest take a
// fixed two clocks. Runs on the system clock.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module main_dtack import main_bus_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  cpu_bus_t bus,
    input  bus_sel_t sel,
    input  logic     rom_ok,
    input  logic     ram_ok,
    input  logic     pxl_cen,
    output logic     dtack_n
);

    dtack_state_e state;
    logic         any_sel;
    logic         other_sel;
    logic         good;     // data ready, one clock late

    assign any_sel   = sel != '0;
    assign other_sel = any_sel && !sel.rom && !sel.ram && !sel.vmem;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= idle;
            good    <= 1'b0;
            dtack_n <= 1'b1;
        end else begin
            good    <= (sel.rom && rom_ok) || (sel.ram && ram_ok) || other_sel;
            dtack_n <= state != ack;    // follows the state by one clock
            case (state)
                idle: begin
                    // internal regions go through wait_mem as a one-cycle delay
                    if (any_sel)
                        state <= sel.vmem ? wait_pxl : wait_mem;
                end
                wait_mem: begin
                    if (bus.as_n)
                        state <= idle;
                    else if (good)
                        state <= ack;
                end
                wait_pxl: begin
                    if (bus.as_n)
                        state <= idle;
                    else if (pxl_cen)
                        state <= ack;
                end
                ack:     if (bus.as_n) state <= hold;
                hold:    state <= idle;
                default: state <= idle;
            endcase
        end
    end

endmodule

// ==== hw/main_read_mux.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// CPU read data path. Picks the selected source, packs the byte-wide
// memories and cabinet inputs into words, and registers the result.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module main_read_mux import main_bus_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  cpu_bus_t bus,
    input  bus_sel_t sel,
    input  mem_rd_t  rd,
    input  cab_in_t  cab,
    input  logic     lrsw,
    output word_t    cpu_din
);

    logic  a1;
    word_t vmem_word;
    word_t pmem_word;
    word_t cab1_word;
    word_t cab2_word;
    word_t mux;

    assign a1 = bus.addr[0];

    always_comb begin
        // fix RAM is byte wide, one byte per word address
        vmem_word = {8'h00, a1 ? rd.vmem[7:0] : rd.vmem[15:8]};
        pmem_word = a1 ? {rd.pmem1, rd.pmem0} : {8'h00, rd.pmem2};

        // players 2 and 4 on the odd word
        cab1_word = a1 ? {cab.start[3], cab.joy4, cab.start[1], cab.joy2} :
                         {cab.start[2], cab.joy3, cab.start[0], cab.joy1};

        // odma low halts the game
        cab2_word = {6'h00, lrsw, cab.odma,
                     a1 ? {cab.dipsw, cab.dip_test, 1'b1, cab.eep_rdy, cab.eep_do} :
                          {cab.service, cab.coin}};
    end

    always_comb begin
        if (sel.rom)
            mux = rd.rom;
        else if (sel.ram)
            mux = rd.ram;
        else if (sel.cpal)
            mux = rd.cpal;
        else if (sel.vmem)
            mux = vmem_word;
        else if (sel.ccu)
            mux = {8'h00, rd.vtimer};
        else if (sel.objram)
            mux = rd.omem;
        else if (sel.pmem)
            mux = pmem_word;
        else if (sel.lmem)
            mux = rd.lmem;
        else if (sel.pair)
            mux = {rd.pair, 8'h00};   // sound latch sits on D15..D8
        else if (sel.cab1)
            mux = cab1_word;
        else if (sel.cab2)
            mux = cab2_word;
        else
            mux = '0;
    end

    always_ff @(posedge clk) begin
        if (reset)
            cpu_din <= '0;
        else
            cpu_din <= mux;
    end

endmodule

// ==== hw/main_bus_glue.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Main CPU bus glue, top level. Connect the 68000 bus to bus, the SDRAM
// ports to rom/ram, the on-board memories to wr/rd, and take the video
// configuration and EEPROM pins from the system latches.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module main_bus_glue import main_bus_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    // CPU side
    input  cpu_bus_t   bus,
    output logic       dtack_n,
    output word_t      cpu_din,
    output logic [2:0] ipl_n,
    output logic       halt_n,
    // external ROM/RAM
    output logic       rom_cs,
    output logic       ram_cs,
    output ext_addr_t  main_addr,
    output logic       ram_we,
    output logic [1:0] ram_dsn,
    input  logic       rom_ok,
    input  logic       ram_ok,
    // on-board memories
    output mem_wr_t    wr,
    input  mem_rd_t    rd,
    // other chips
    output logic       objreg_cs,
    output logic       objcha_n,
    output logic       ccu_cs,
    output logic       sdon,
    output video_cfg_t video,
    output logic       eep_clk,
    output logic       eep_di,
    output logic       eep_cs,
    // cabinet and video timing
    input  cab_in_t    cab,
    input  logic       lvbl,
    input  logic       disp,
    input  logic       pxl_cen,
    input  logic       dip_pause
);

    bus_sel_t sel;
    word_t    sys1_q;
    word_t    sys2_q;
    logic     wr_cyc;
    logic     uds, lds, a1;
    logic     l_r;        // top address bit of the on-board memories
    logic     fmode, fsel;

    main_addr_decode u_decode (
        .bus       ( bus       ),
        .sel       ( sel       ),
        .main_addr ( main_addr )
    );

    main_sys_latch u_sys1 (
        .clk   ( clk      ),
        .reset ( reset    ),
        .sel   ( sel.sys1 ),
        .bus   ( bus      ),
        .q     ( sys1_q   )
    );

    main_sys_latch u_sys2 (
        .clk   ( clk      ),
        .reset ( reset    ),
        .sel   ( sel.sys2 ),
        .bus   ( bus      ),
        .q     ( sys2_q   )
    );

    main_vblank_irq u_vblank (
        .clk    ( clk        ),
        .reset  ( reset      ),
        .lvbl   ( lvbl       ),
        .enable ( sys1_q[10] ),   // level 5 mask
        .ipl_n  ( ipl_n      )
    );

    main_dtack u_dtack (
        .clk     ( clk     ),
        .reset   ( reset   ),
        .bus     ( bus     ),
        .sel     ( sel     ),
        .rom_ok  ( rom_ok  ),
        .ram_ok  ( ram_ok  ),
        .pxl_cen ( pxl_cen ),
        .dtack_n ( dtack_n )
    );

    main_read_mux u_rdmux (
        .clk     ( clk        ),
        .reset   ( reset      ),
        .bus     ( bus        ),
        .sel     ( sel        ),
        .rd      ( rd         ),
        .cab     ( cab        ),
        .lrsw    ( video.lrsw ),
        .cpu_din ( cpu_din    )
    );

    assign wr_cyc = !bus.rnw;
    assign uds    = !bus.ds_n[1];
    assign lds    = !bus.ds_n[0];
    assign a1     = bus.addr[0];

    // system register 1
    assign l_r     = sys1_q[7];
    assign eep_clk = sys1_q[2];
    assign eep_cs  = sys1_q[1];
    assign eep_di  = sys1_q[0];
    // system register 2
    assign fmode   = sys2_q[1];
    assign fsel    = sys2_q[0];

    always_comb begin
        video.pri       = sys1_q[14];
        video.gvflip    = sys1_q[6];
        video.ghflip    = sys1_q[5];
        video.lrsw      = fmode ? disp : fsel;
        video.psac_bank = sys2_q[7:4];
    end

    always_comb begin
        wr.cpal_we    = ~bus.ds_n & {2{sel.cpal   && wr_cyc}};
        wr.omem_we    = ~bus.ds_n & {2{sel.objram && wr_cyc}};
        wr.lmem_we    = ~bus.ds_n & {2{sel.lmem   && wr_cyc}};
        // fix RAM only listens to the lower byte, A1 picks the half
        wr.vmem_we    = {2{sel.vmem && wr_cyc && lds}} & {!a1, a1};
        wr.pmem_we[0] = sel.pmem && wr_cyc && lds &&  a1;
        wr.pmem_we[1] = sel.pmem && wr_cyc && uds &&  a1;
        wr.pmem_we[2] = sel.pmem && wr_cyc && lds && !a1;
        wr.pair_we    = sel.pair && wr_cyc && uds;
        wr.cpal_addr  = {l_r, bus.addr[9:0]};
        wr.vmem_addr  = {l_r, bus.addr[11:1]};
        wr.pmem_addr  = {l_r, bus.addr[14:1]};
    end

    assign rom_cs    = sel.rom;
    assign ram_cs    = sel.ram;
    assign ram_we    = sel.ram && wr_cyc;
    assign ram_dsn   = bus.ds_n;
    assign objreg_cs = sel.objreg;
    assign objcha_n  = !sel.objcha;
    assign ccu_cs    = sel.ccu;
    assign sdon      = sel.sdon;

    always_ff @(posedge clk) begin
        if (reset)
            halt_n <= 1'b0;       // CPU held during reset
        else
            halt_n <= dip_pause;
    end

endmodule

// ==== test/tb_main_bus.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the main CPU bus glue. Acts as the 68000 bus master and
// replays the cycles listed in test/main_bus_cases.txt.
// Run it from the project root.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_main_bus import main_bus_pkg::*; ();

    localparam logic [31:0] SEED = 32'hcf670245;

    logic       clk;
    logic       reset;
    cpu_bus_t   bus;
    logic       dtack_n;
    word_t      cpu_din;
    logic [2:0] ipl_n;
    logic       halt_n;
    logic       rom_cs;
    logic       ram_cs;
    ext_addr_t  main_addr;
    logic       ram_we;
    logic [1:0] ram_dsn;
    logic       rom_ok;
    logic       ram_ok;
    mem_wr_t    wr;
    mem_rd_t    rd;
    logic       objreg_cs;
    logic       objcha_n;
    logic       ccu_cs;
    logic       sdon;
    video_cfg_t video;
    logic       eep_clk;
    logic       eep_di;
    logic       eep_cs;
    cab_in_t    cab;
    logic       lvbl;
    logic       disp;
    logic       pxl_cen;
    logic       dip_pause;
    logic [1:0] pxl_cnt;

    logic [7:0]  op_q[$];
    addr_t       addr_q[$];
    logic [1:0]  ds_q[$];
    word_t       wdata_q[$];
    int          seed_q[$];
    logic [31:0] exp_q[$];
    int          n_cases = 0;
    int          errors = 0;
    logic [31:0] lfsr;
    mem_rd_t     rd_v;       // values driven on rd for the current cycle
    cab_in_t     cab_v;
    logic        lrsw_exp;   // last lrsw seen by a status line

    main_bus_glue i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // pixel clock enable every fourth cycle
    always @(posedge clk) begin
        pxl_cnt <= pxl_cnt + 2'd1;
        pxl_cen <= pxl_cnt == 2'd3;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? (s >> 1) ^ 32'h80200003 : s >> 1;
    endfunction

    // memory and cabinet data plus the ok delay, one LFSR step per bit
    task automatic fill_inputs(input int seed_idx, output logic [2:0] dly);
        lfsr = SEED;
        repeat (seed_idx * 8) lfsr = lfsr_step(lfsr);
        for (int i = 0; i < $bits(mem_rd_t); i++) begin
            rd_v[i] = lfsr[0];
            lfsr = lfsr_step(lfsr);
        end
        for (int i = 0; i < $bits(cab_in_t); i++) begin
            cab_v[i] = lfsr[0];
            lfsr = lfsr_step(lfsr);
        end
        for (int i = 0; i < 3; i++) begin
            dly[i] = lfsr[0];
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // source codes 1 (rom) to b (cab2) as in the case file
    // any other code reads zero
    function automatic word_t expected_read(input logic [3:0] src, input logic a1,
                                            input mem_rd_t r, input cab_in_t c,
                                            input logic lr);
        case (src)
            4'h1: return r.rom;
            4'h2: return r.ram;
            4'h3: return r.cpal;
            4'h4: return {8'h00, (a1 ? r.vmem[7:0] : r.vmem[15:8])};
            4'h5: return {8'h00, r.vtimer};
            4'h6: return r.omem;
            4'h7: return a1 ? {r.pmem1, r.pmem0} : {8'h00, r.pmem2};
            4'h8: return r.lmem;
            4'h9: return {r.pair, 8'h00};
            4'ha: return a1 ? {c.start[3], c.joy4, c.start[1], c.joy2} :
                              {c.start[2], c.joy3, c.start[0], c.joy1};
            4'hb: return {6'h00, lr, c.odma, (a1 ? {c.dipsw, c.dip_test, 1'b1, c.eep_rdy,
                          c.eep_do} : {c.service, c.coin})};
            default: return '0;
        endcase
    endfunction

    task automatic load_cases();
        int               fd;
        int               cnt;
        logic [8*128-1:0] line;
        logic [7:0]       op;
        addr_t            a;
        logic [1:0]       d;
        word_t            w;
        int               s;
        logic [31:0]      e;
        fd = $fopen("test/main_bus_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open test/main_bus_cases.txt");
            $display("*** TEST FAILED ***");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                line = '0;
                if ($fgets(line, fd) != 0) begin
                    cnt = $sscanf(line, "%s %h %h %h %d %h", op, a, d, w, s, e);
                    if (cnt == 6) begin   // comment lines fail the scan
                        op_q.push_back(op);
                        addr_q.push_back(a);
                        ds_q.push_back(d);
                        wdata_q.push_back(w);
                        seed_q.push_back(s);
                        exp_q.push_back(e);
                    end
                end
            end
            $fclose(fd);
            n_cases = op_q.size();
        end
    endtask

    task automatic check_read(input int n, input logic [3:0] src);
        word_t      want;
        logic [2:0] blk;
        want = expected_read(src, addr_q[n][0], rd_v, cab_v, lrsw_exp);
        blk  = addr_q[n][22:20];
        if (cpu_din !== want) begin
            $display("Fail %0t: case %0d read %h, expected %h", $time, n, cpu_din, want);
            errors++;
        end
        if (main_addr !== exp_q[n][20:0]) begin
            $display("Fail %0t: case %0d main_addr %h, expected %h", $time, n, main_addr,
                     exp_q[n][20:0]);
            errors++;
        end
        if (rom_cs !== (src == 4'h1) || ram_cs !== (src == 4'h2)) begin
            $display("Fail %0t: case %0d rom_cs %b ram_cs %b", $time, n, rom_cs, ram_cs);
            errors++;
        end
        // objreg sits in the graphics block and objcha in the misc block
        if (objreg_cs !== (src == 4'hc && blk == REGION_GFX)
            || objcha_n !== !(src == 4'hc && blk == REGION_MISC)
            || ccu_cs !== (src == 4'h5) || sdon !== 1'b0) begin
            $display("Fail %0t: case %0d objreg_cs %b objcha_n %b ccu_cs %b sdon %b",
                     $time, n, objreg_cs, objcha_n, ccu_cs, sdon);
            errors++;
        end
    endtask

    task automatic check_write(input int n);
        logic [15:0] got;
        got = {ram_we, wr.pair_we, wr.pmem_we, wr.lmem_we, wr.omem_we, wr.vmem_we,
               wr.cpal_we, wr.cpal_addr[10], wr.vmem_addr[11], wr.pmem_addr[14]};
        if (got !== exp_q[n][15:0]) begin
            $display("Fail %0t: case %0d write enables %h, expected %h", $time, n, got,
                     exp_q[n][15:0]);
            errors++;
        end
        if (wr.cpal_addr[9:0] !== addr_q[n][9:0] || wr.vmem_addr[10:0] !== addr_q[n][11:1]
            || wr.pmem_addr[13:0] !== addr_q[n][14:1]) begin
            $display("Fail %0t: case %0d on-board address low bits wrong", $time, n);
            errors++;
        end
        if (ram_dsn !== ds_q[n]) begin
            $display("Fail %0t: case %0d ram_dsn %b, expected %b", $time, n, ram_dsn,
                     ds_q[n]);
            errors++;
        end
    endtask

    // drive video timing and pause and then look at the static outputs
    task automatic check_status(input int n);
        logic [14:0] got;
        @(posedge clk);
        dip_pause <= seed_q[n][2];
        disp      <= seed_q[n][1];
        lvbl      <= seed_q[n][0];
        repeat (3) @(posedge clk);
        @(negedge clk);
        got = {halt_n, ipl_n, eep_clk, eep_cs, eep_di, video};
        if (got !== exp_q[n][14:0]) begin
            $display("Fail %0t: case %0d status %h, expected %h", $time, n, got,
                     exp_q[n][14:0]);
            errors++;
        end
        lrsw_exp = exp_q[n][4];
    endtask

    task automatic run_cycle(input int n);
        logic [3:0] src;
        logic [2:0] dly;
        logic       mem;
        logic       ok_up;
        int         waited;
        int         limit;
        src   = exp_q[n][27:24];
        mem   = op_q[n] == "w" ? exp_q[n][15] : (src == 4'h1 || src == 4'h2);
        limit = op_q[n] == "u" ? 20 : 40;
        ok_up = 1'b0;
        waited = 0;
        fill_inputs(seed_q[n], dly);
        @(posedge clk);
        bus.addr  <= addr_q[n];
        bus.ds_n  <= ds_q[n];
        bus.rnw   <= op_q[n] != "w";
        bus.wdata <= wdata_q[n];
        bus.as_n  <= 1'b0;
        rd        <= rd_v;
        cab       <= cab_v;
        @(negedge clk);
        while (dtack_n && waited < limit) begin
            @(posedge clk);
            if (waited == dly) begin      // memory answers late
                rom_ok <= 1'b1;
                ram_ok <= 1'b1;
                ok_up = 1'b1;
            end
            @(negedge clk);
            waited++;
        end
        if (op_q[n] == "u") begin
            if (!dtack_n) begin
                $display("case %0d: DTACK came on an unmapped address", n);
                errors++;
            end else begin
                $display("case %0d: no DTACK within %0d cycles, as expected", n, limit);
            end
            if (cpu_din !== '0) begin
                $display("Fail %0t: case %0d unmapped read gave %h", $time, n, cpu_din);
                errors++;
            end
            if ({rom_cs, ram_cs, objreg_cs, objcha_n, ccu_cs, sdon} !== 6'b000100) begin
                $display("Fail %0t: case %0d chip select active on an unmapped address",
                         $time, n);
                errors++;
            end
        end else if (dtack_n) begin
            $display("case %0d: timeout, no DTACK within %0d cycles", n, limit);
            errors++;
        end else begin
            if (mem && !ok_up) begin
                $display("case %0d: DTACK came before the memory ok", n);
                errors++;
            end
            if (op_q[n] == "r")
                check_read(n, src);
            else
                check_write(n);
        end
        @(posedge clk);
        bus.as_n <= 1'b1;
        bus.ds_n <= 2'b11;
        rom_ok   <= 1'b0;
        ram_ok   <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (!dtack_n && waited < 10) begin
            @(negedge clk);
            waited++;
        end
        if (!dtack_n) begin
            $display("case %0d: DTACK stayed low after the strobes were released", n);
            errors++;
        end
    endtask

    initial begin
        wait (n_cases > 0);
        repeat (n_cases * 200 + 8) @(posedge clk);
        $display("watchdog: run went past %0d cycles, stopping", n_cases * 200 + 8);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        reset     = 1'b1;
        bus       = '0;
        bus.as_n  = 1'b1;
        bus.ds_n  = 2'b11;
        bus.rnw   = 1'b1;
        rd        = '0;
        cab       = '0;
        rom_ok    = 1'b0;
        ram_ok    = 1'b0;
        lvbl      = 1'b1;
        disp      = 1'b0;
        dip_pause = 1'b1;
        pxl_cen   = 1'b0;
        pxl_cnt   = '0;
        lrsw_exp  = 1'b0;   // both latches clear
        load_cases();
        if (n_cases == 0) begin
            $display("no cases found in test/main_bus_cases.txt");
            errors++;
        end
        repeat (7) @(posedge clk);
        @(negedge clk);
        if (halt_n !== 1'b0) begin
            $display("Fail %0t: halt_n %b during reset", $time, halt_n);
            errors++;
        end
        @(posedge clk);
        reset <= 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        if (dtack_n !== 1'b1 || halt_n !== 1'b1 || ipl_n !== 3'b111) begin
            $display("Fail %0t: after reset dtack_n %b halt_n %b ipl_n %b", $time,
                     dtack_n, halt_n, ipl_n);
            errors++;
        end
        for (int n = 0; n < n_cases; n++) begin
            if (op_q[n] == "s")
                check_status(n);
            else
                run_cycle(n);
        end
        $display("%0d cases run, %0d errors", n_cases, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// ==== test/main_bus_cases.txt ====
# op addr(A23..A1) ds_n wdata seed expect, all hex except seed
# op r: expect = source<<24 | main_addr, w: write enables, s: seed = pause,disp,lvbl
r 000100 0 0000 1 1000100
r 080234 0 0000 2 1100234
r 100456 0 0000 3 1080456
r 1c0012 0 0000 4 21c0012
r 1800ab 0 0000 5 31800ab
r 3a0011 0 0000 6 41a0011
r 3a0010 0 0000 7 41a0010
r 260000 0 0000 8 5060000
r 300020 0 0000 9 6100020
r 360001 0 0000 10 7160001
r 360002 0 0000 11 7160002
r 380005 0 0000 12 8180005
r 2c0000 0 0000 13 90c0000
r 240000 0 0000 14 a040000
r 240001 0 0000 15 a040001
r 240002 0 0000 16 b040002
r 240003 0 0000 17 b040003
r 320000 0 0000 18 c120000
r 2e0000 0 0000 19 c0e0000
u 700000 0 0000 20 0
u 220000 0 0000 21 0
w 1800ab 0 1234 22 0018
w 1800ab 1 5678 23 0010
w 3a0011 0 00aa 24 0020
w 3a0010 2 0055 25 0040
w 360001 0 abcd 26 1800
w 360002 0 00ef 27 2000
w 380005 0 1111 28 0600
w 300020 1 2222 29 0100
w 2c0000 1 3300 30 4000
w 2c0000 2 0033 31 0000
w 1c0012 0 4444 32 8000
w 240004 2 0080 33 0007
w 1800ab 0 1234 34 001f
w 3a0011 0 00aa 35 0027
s 000000 3 0000 5 7800
w 240004 1 4400 36 0007
w 240004 2 0067 37 0000
w 240006 0 0051 38 0000
s 000000 3 0000 5 7ff5
w 240006 2 0052 39 0000
s 000000 3 0000 7 7ff5
r 240003 0 0000 40 b040003
s 000000 3 0000 5 7fe5
s 000000 3 0000 4 57e5
s 000000 3 0000 0 17e5
w 240004 1 4000 41 0000
s 000000 3 0000 5 7fe5

// ==== tb.f ====
hw/main_bus_pkg.sv
hw/main_addr_decode.sv
hw/main_sys_latch.sv
hw/main_vblank_irq.sv
hw/main_dtack.sv
hw/main_read_mux.sv
hw/main_bus_glue.sv
test/tb_main_bus.sv
